// ==== dv/mips_tb.sv ====
module mips_tb;
    import mips_pkg::*;

    localparam int IMEM_DEPTH = 64;
    localparam int DMEM_DEPTH = 64;
    localparam int IA_W       = $clog2(IMEM_DEPTH);
    localparam int DA_W       = $clog2(DMEM_DEPTH);
    localparam int CLK_PERIOD = 8;
    localparam int MAX_EXP    = 128;

    logic              i_clk = 1'b0;
    logic              i_rst;
    logic              i_stall;
    logic              i_imem_we;
    logic [IA_W-1:0]   i_imem_addr;
    logic [31:0]       i_imem_data;
    logic [DA_W-1:0]   i_dmem_dbg_addr;
    logic [31:0]       o_dmem_dbg_data;
    logic [31:0]       o_pc;
    logic              o_wb_valid;
    logic [4:0]        o_wb_addr;
    logic [31:0]       o_wb_data;

    logic [31:0] prog [IMEM_DEPTH];
    int          prog_len;
    logic [31:0] halt_pc;
    logic [4:0]  exp_addr [MAX_EXP];  // Expected retire stream, program order
    logic [31:0] exp_data [MAX_EXP];
    int          n_exp;
    logic [31:0] mregs [32];          // ISA model state
    logic [31:0] mmem [DMEM_DEPTH];
    bit          mwritten [DMEM_DEPTH];
    bit          stall_plan [$];
    int          stall_total;
    int          retired = 0;
    int          timeout_cycles = 0;
    logic [31:0] pc_before;           // Fetch PC and stall level at the last rising edge
    logic        stall_at_edge;

    mips #(.IMEM_DEPTH(IMEM_DEPTH), .DMEM_DEPTH(DMEM_DEPTH)) uut (
        .i_clk           (i_clk),
        .i_rst           (i_rst),
        .i_stall         (i_stall),
        .i_imem_we       (i_imem_we),
        .i_imem_addr     (i_imem_addr),
        .i_imem_data     (i_imem_data),
        .i_dmem_dbg_addr (i_dmem_dbg_addr),
        .o_dmem_dbg_data (o_dmem_dbg_data),
        .o_pc            (o_pc),
        .o_wb_valid      (o_wb_valid),
        .o_wb_addr       (o_wb_addr),
        .o_wb_data       (o_wb_data)
    );

    always #(CLK_PERIOD / 2) i_clk = ~i_clk;

    function automatic logic [31:0] rtype_word(input logic [4:0] rs, input logic [4:0] rt,
                                               input logic [4:0] rd, input logic [5:0] funct);
        instr_t w;
        w          = '0;
        w.r.opcode = OP_RTYPE;
        w.r.rs     = rs;
        w.r.rt     = rt;
        w.r.rd     = rd;
        w.r.funct  = funct;
        return w;
    endfunction

    function automatic logic [31:0] itype_word(input logic [5:0] op, input logic [4:0] rs,
                                               input logic [4:0] rt, input logic [15:0] imm);
        instr_t w;
        w.i.opcode = op;
        w.i.rs     = rs;
        w.i.rt     = rt;
        w.i.imm16  = imm;
        return w;
    endfunction

    function automatic logic [31:0] jump_word(input logic [25:0] target);
        instr_t w;
        w.j.opcode   = OP_J;
        w.j.target26 = target; // Word address
        return w;
    endfunction

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Test failures found");
        $fatal(1, "stopped at the first failed check");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("Mismatch %s: expected 0x%08h, got 0x%08h", name, expected, actual);
        $display("Test failures found");
        $fatal(1, "stopped at the first failed check");
    endtask

    task automatic emit(input logic [31:0] w);
        prog[prog_len] = w;
        prog_len++;
    endtask

    task automatic build_program();
        logic [15:0] imm [6];
        for (int k = 0; k < 6; k++) begin
            imm[k] = 16'($urandom);
        end
        imm[1]   = imm[1] | 16'h0001; // Keeps r1 != r2
        imm[3]   = imm[3] | 16'h0001; // Keeps r12 != r9
        prog_len = 0;
        emit(itype_word(OP_ADDI, 0, 1, imm[0]));    // 0
        emit(itype_word(OP_ADDI, 1, 2, imm[1]));    // 1  EX/MEM forward
        emit(rtype_word(1, 2, 3, FN_ADDU));         // 2  Both forward paths
        emit(rtype_word(3, 1, 4, FN_SUBU));         // 3
        emit(rtype_word(4, 3, 5, FN_AND));          // 4
        emit(rtype_word(5, 2, 6, FN_OR));           // 5
        emit(rtype_word(4, 6, 7, FN_SLT));          // 6
        emit(itype_word(OP_ADDI, 1, 0, imm[2]));    // 7  Write to r0, no retire
        emit(itype_word(OP_SW, 0, 3, 16'd0));       // 8
        emit(itype_word(OP_SW, 0, 6, 16'd4));       // 9
        emit(itype_word(OP_LW, 0, 8, 16'd0));       // 10
        emit(rtype_word(8, 2, 9, FN_ADDU));         // 11 Load-use
        emit(itype_word(OP_LW, 0, 10, 16'd4));      // 12
        emit(itype_word(OP_BEQ, 10, 6, 16'd1));     // 13 Taken, on a fresh load
        emit(itype_word(OP_ADDI, 0, 11, 16'd1));    // 14 Wrong path
        emit(itype_word(OP_ADDI, 9, 12, imm[3]));   // 15
        emit(itype_word(OP_BNE, 12, 9, 16'd1));     // 16 Taken, source in EX
        emit(itype_word(OP_ADDI, 0, 13, 16'd7));    // 17 Wrong path
        emit(itype_word(OP_BEQ, 1, 2, 16'd1));      // 18 Not taken
        emit(itype_word(OP_ADDI, 12, 14, imm[4]));  // 19
        emit(itype_word(OP_BNE, 14, 14, 16'd1));    // 20 Not taken
        emit(itype_word(OP_ADDI, 14, 17, imm[5]));  // 21
        emit(jump_word(26'd24));                    // 22
        emit(itype_word(OP_ADDI, 0, 15, 16'd9));    // 23 Wrong path
        emit(itype_word(OP_SW, 0, 14, 16'd8));      // 24
        emit(rtype_word(14, 1, 16, FN_SLT));        // 25
        emit(itype_word(OP_SW, 0, 16, 16'd12));     // 26 Store data from EX/MEM
        emit(itype_word(OP_LW, 0, 18, 16'd8));      // 27
        emit(jump_word(26'd28));                    // 28 Halt loop
    endtask

    task automatic model_write(input logic [4:0] rd, input logic [31:0] value);
        if (rd != 5'd0) begin
            mregs[rd]       = value;
            exp_addr[n_exp] = rd;
            exp_data[n_exp] = value;
            n_exp++;
        end
    endtask

    // Instruction-level model, one instruction per step
    task automatic run_model();
        instr_t      ins;
        logic [31:0] a, b, imm, addr, res;
        int          pc, next_pc;
        pc    = 0;
        n_exp = 0;
        for (int r = 0; r < 32; r++) begin
            mregs[r] = '0;
        end
        for (int steps = 0; steps < 200; steps++) begin
            ins = prog[pc];
            if (ins.j.opcode == OP_J && int'(ins.j.target26) == pc) begin
                break; // Reached the halt loop
            end
            a       = mregs[ins.i.rs];
            b       = mregs[ins.i.rt];
            imm     = {{16{ins.i.imm16[15]}}, ins.i.imm16};
            addr    = a + imm;
            next_pc = pc + 1;
            case (ins.r.opcode)
                OP_RTYPE: begin
                    case (ins.r.funct)
                        FN_ADDU: res = a + b;
                        FN_SUBU: res = a - b;
                        FN_AND:  res = a & b;
                        FN_OR:   res = a | b;
                        default: res = {31'd0, $signed(a) < $signed(b)};
                    endcase
                    model_write(ins.r.rd, res);
                end
                OP_ADDI: model_write(ins.i.rt, addr);
                OP_LW:   model_write(ins.i.rt, mmem[addr[DA_W+1:2]]);
                OP_SW: begin
                    mmem[addr[DA_W+1:2]]     = b;
                    mwritten[addr[DA_W+1:2]] = 1'b1;
                end
                OP_BEQ: if (a == b) next_pc = pc + 1 + int'($signed(ins.i.imm16));
                OP_BNE: if (a != b) next_pc = pc + 1 + int'($signed(ins.i.imm16));
                OP_J:   next_pc = int'(ins.j.target26);
                default: ;
            endcase
            pc = next_pc;
        end
    endtask

    task automatic plan_stalls();
        int gap, len;
        stall_total = 0;
        for (int p = 0; p < 5; p++) begin
            gap = 2 + int'($urandom % 7);
            len = 1 + int'($urandom % 3);
            for (int k = 0; k < gap; k++) stall_plan.push_back(1'b0);
            for (int k = 0; k < len; k++) stall_plan.push_back(1'b1);
            stall_total += len;
        end
    endtask

    always @(posedge i_clk) begin
        if (o_wb_valid) begin
            retired <= retired + 1;
        end
    end

    always @(posedge i_clk) begin
        pc_before     <= o_pc;
        stall_at_edge <= i_stall;
    end

    // Checked mid-cycle, where DUT outputs and the counter are settled
    retire_bound: assert property (@(negedge i_clk) disable iff (i_rst)
        o_wb_valid |-> retired < n_exp)
        else fail_run("A register write retired after the whole program had retired");
    retire_addr: assert property (@(negedge i_clk) disable iff (i_rst)
        o_wb_valid && retired < n_exp |-> o_wb_addr == exp_addr[retired])
        else report_mismatch("o_wb_addr", 32'(exp_addr[retired]), 32'(o_wb_addr));
    retire_data: assert property (@(negedge i_clk) disable iff (i_rst)
        o_wb_valid && retired < n_exp |-> o_wb_data == exp_data[retired])
        else report_mismatch("o_wb_data", exp_data[retired], o_wb_data);
    stall_quiet: assert property (@(negedge i_clk) disable iff (i_rst)
        i_stall |-> !o_wb_valid)
        else fail_run("A register write retired while the stall input was high");
    pc_frozen: assert property (@(negedge i_clk) disable iff (i_rst)
        stall_at_edge |-> o_pc == pc_before)
        else report_mismatch("o_pc", pc_before, o_pc);

    initial begin
        wait (timeout_cycles != 0);
        #(timeout_cycles * CLK_PERIOD);
        $display("Timeout: only %0d of %0d register writes retired in time", retired, n_exp);
        $display("Test failures found");
        $fatal(1, "watchdog expired");
    end

    initial begin
        void'($urandom(30995));
        i_rst           = 1'b1;
        i_stall         = 1'b1; // Core frozen while the program loads
        i_imem_we       = 1'b0;
        i_imem_addr     = '0;
        i_imem_data     = '0;
        i_dmem_dbg_addr = '0;
        build_program();
        run_model();
        plan_stalls();
        halt_pc        = 32'((prog_len - 1) * 4);
        timeout_cycles = prog_len * 4 + stall_total + 64;

        for (int k = 0; k < prog_len; k++) begin
            @(posedge i_clk);
            i_imem_we   <= 1'b1;
            i_imem_addr <= IA_W'(k);
            i_imem_data <= prog[k];
            if (k == 1) begin
                i_rst <= 1'b0; // Two edges in reset
            end
        end
        @(posedge i_clk);
        i_imem_we <= 1'b0;
        i_stall   <= 1'b0;

        foreach (stall_plan[c]) begin
            @(posedge i_clk);
            i_stall <= stall_plan[c];
        end
        @(posedge i_clk);
        i_stall <= 1'b0;

        while (retired < n_exp) @(posedge i_clk);
        repeat (8) @(posedge i_clk); // Room for any stray retirement

        for (int k = 0; k < DMEM_DEPTH; k++) begin
            if (mwritten[k]) begin
                @(posedge i_clk);
                i_dmem_dbg_addr <= DA_W'(k);
                @(negedge i_clk);
                assert (o_dmem_dbg_data == mmem[k])
                    else report_mismatch("o_dmem_dbg_data", mmem[k], o_dmem_dbg_data);
            end
        end

        // Fetch alternates between the halt jump and the flushed slot behind it
        @(negedge i_clk);
        assert (o_pc == halt_pc || o_pc == halt_pc + 32'd4)
            else report_mismatch("o_pc", halt_pc, o_pc);

        $display("All tests passed!");
        $finish;
    end

endmodule

// ==== filelist.f ====
src/mips_pkg.sv
src/instruction_fetch.sv
src/hazard_detection.sv
src/instruction_decode.sv
src/execution.sv
src/data_memory.sv
src/mips.sv
dv/mips_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module mips_tb -Mdir obj_dir -f filelist.f

# The simulator status is masked by tee, the log decides
./obj_dir/Vmips_tb 2>&1 | tee sim.log

if grep -q "Test failures found" sim.log; then
    echo "Simulation FAILED, see sim.log"
    exit 1
fi
echo "Simulation finished without failures"

// ==== src/data_memory.sv ====
module data_memory #(
    parameter int DMEM_DEPTH = 64
) (
    input  logic                            i_clk,
    input  logic                            i_rst,
    input  logic                            i_stall,
    input  logic [mips_pkg::DATA_W-1:0]     i_alu,
    input  logic [mips_pkg::DATA_W-1:0]     i_store,
    input  logic [mips_pkg::REG_ADDR_W-1:0] i_rd,
    input  logic                            i_reg_write,
    input  logic                            i_mem_read,
    input  logic                            i_mem_write,
    input  logic [$clog2(DMEM_DEPTH)-1:0]   i_dbg_addr,
    output logic [mips_pkg::DATA_W-1:0]     o_dbg_data,
    output logic [mips_pkg::DATA_W-1:0]     o_wb_alu,
    output logic [mips_pkg::DATA_W-1:0]     o_wb_load,
    output logic [mips_pkg::REG_ADDR_W-1:0] o_wb_rd,
    output logic                            o_wb_reg_write,
    output logic                            o_wb_mem_to_reg
);
    import mips_pkg::*;

    localparam int AW = $clog2(DMEM_DEPTH);

    logic [DATA_W-1:0] dmem [DMEM_DEPTH];
    logic [AW-1:0]     word;

    assign word       = i_alu[AW+1:2]; // Byte address to word index
    assign o_dbg_data = dmem[i_dbg_addr];

    always_ff @(posedge i_clk) begin
        if (i_mem_write && !i_stall) begin
            dmem[word] <= i_store;
        end
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            o_wb_reg_write  <= 1'b0;
            o_wb_mem_to_reg <= 1'b0;
            o_wb_rd         <= '0;
        end else if (!i_stall) begin
            o_wb_reg_write  <= i_reg_write;
            o_wb_mem_to_reg <= i_mem_read;
            o_wb_rd         <= i_rd;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_stall) begin
            o_wb_alu  <= i_alu;
            o_wb_load <= dmem[word];
        end
    end

    assert property (@(posedge i_clk) disable iff (i_rst) !(i_mem_read && i_mem_write))
        else $error("Data memory read and write in one cycle");

endmodule

// ==== src/execution.sv ====
module execution (
    input  logic                            i_clk,
    input  logic                            i_rst,
    input  logic                            i_stall,
    input  logic [mips_pkg::DATA_W-1:0]     i_a,
    input  logic [mips_pkg::DATA_W-1:0]     i_b,
    input  logic [mips_pkg::DATA_W-1:0]     i_imm,
    input  logic [mips_pkg::REG_ADDR_W-1:0] i_rs,
    input  logic [mips_pkg::REG_ADDR_W-1:0] i_rt,
    input  logic [mips_pkg::REG_ADDR_W-1:0] i_rd,
    input  logic [2:0]                      i_alu_op,
    input  logic                            i_alu_src,
    input  logic                            i_reg_write,
    input  logic                            i_mem_read,
    input  logic                            i_mem_write,
    input  logic                            i_wb_we,
    input  logic [mips_pkg::REG_ADDR_W-1:0] i_wb_addr,
    input  logic [mips_pkg::DATA_W-1:0]     i_wb_data,
    output logic [mips_pkg::DATA_W-1:0]     o_mem_alu,
    output logic [mips_pkg::DATA_W-1:0]     o_mem_store,
    output logic [mips_pkg::REG_ADDR_W-1:0] o_mem_rd,
    output logic                            o_mem_reg_write,
    output logic                            o_mem_mem_read,
    output logic                            o_mem_mem_write
);
    import mips_pkg::*;

    logic [DATA_W-1:0] op_a, fwd_b, op_b, result;
    logic              mem_fwd_ok;

    // EX/MEM of a load holds an address, never forwarded
    assign mem_fwd_ok = o_mem_reg_write && !o_mem_mem_read;

    assign op_a  = (mem_fwd_ok && o_mem_rd == i_rs) ? o_mem_alu :
                   (i_wb_we && i_wb_addr == i_rs)   ? i_wb_data : i_a;
    assign fwd_b = (mem_fwd_ok && o_mem_rd == i_rt) ? o_mem_alu :
                   (i_wb_we && i_wb_addr == i_rt)   ? i_wb_data : i_b;
    assign op_b  = i_alu_src ? i_imm : fwd_b;

    always_comb begin
        case (i_alu_op)
            ALU_SUB: result = op_a - op_b;
            ALU_AND: result = op_a & op_b;
            ALU_OR:  result = op_a | op_b;
            ALU_SLT: result = {{(DATA_W-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            default: result = op_a + op_b; // ADD and address math
        endcase
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            o_mem_reg_write <= 1'b0;
            o_mem_mem_read  <= 1'b0;
            o_mem_mem_write <= 1'b0;
            o_mem_rd        <= '0;
        end else if (!i_stall) begin
            o_mem_reg_write <= i_reg_write;
            o_mem_mem_read  <= i_mem_read;
            o_mem_mem_write <= i_mem_write;
            o_mem_rd        <= i_rd;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_stall) begin
            o_mem_alu   <= result;
            o_mem_store <= fwd_b; // Store data after forwarding
        end
    end

endmodule

// ==== src/hazard_detection.sv ====
module hazard_detection (
    input  logic [mips_pkg::REG_ADDR_W-1:0] i_id_rs,
    input  logic [mips_pkg::REG_ADDR_W-1:0] i_id_rt,
    input  logic                            i_id_is_branch,
    input  logic                            i_id_uses_rt,
    input  logic [mips_pkg::REG_ADDR_W-1:0] i_ex_rd,
    input  logic                            i_ex_reg_write,
    input  logic                            i_ex_mem_read,
    input  logic [mips_pkg::REG_ADDR_W-1:0] i_mem_rd,
    input  logic                            i_mem_mem_read,
    input  logic                            i_redirect,
    output logic                            o_hold,
    output logic                            o_flush
);

    logic load_use;
    logic branch_ex;
    logic branch_mem;

    // Load in EX feeding the instruction in decode
    assign load_use = i_ex_mem_read && i_ex_rd != '0
                      && (i_ex_rd == i_id_rs || (i_id_uses_rt && i_ex_rd == i_id_rt));

    // Branch compares in decode, so an EX result is one cycle too late
    assign branch_ex = i_id_is_branch && i_ex_reg_write
                       && (i_ex_rd == i_id_rs || i_ex_rd == i_id_rt);

    // Load data only appears at writeback
    assign branch_mem = i_id_is_branch && i_mem_mem_read && i_mem_rd != '0
                        && (i_mem_rd == i_id_rs || i_mem_rd == i_id_rt);

    assign o_hold  = load_use || branch_ex || branch_mem;
    assign o_flush = i_redirect && !o_hold; // Redirect from a held branch is not yet valid

    // Branch check in EX relies on decode clearing the write enable for r0
    always_comb begin
        assert (!i_ex_reg_write || i_ex_rd != '0)
            else $error("Register write in EX targets register 0");
    end

endmodule

// ==== src/instruction_decode.sv ====
module instruction_decode (
    input  logic                            i_clk,
    input  logic                            i_rst,
    input  logic                            i_stall,
    input  logic                            i_hold,
    input  logic [mips_pkg::DATA_W-1:0]     i_instr,
    input  logic [mips_pkg::DATA_W-1:0]     i_pc4,
    input  logic                            i_wb_we,
    input  logic [mips_pkg::REG_ADDR_W-1:0] i_wb_addr,
    input  logic [mips_pkg::DATA_W-1:0]     i_wb_data,
    input  logic [mips_pkg::REG_ADDR_W-1:0] i_exmem_rd,
    input  logic                            i_exmem_reg_write,
    input  logic [mips_pkg::DATA_W-1:0]     i_exmem_alu,
    output logic                            o_redirect,
    output logic [mips_pkg::DATA_W-1:0]     o_target,
    output logic [mips_pkg::REG_ADDR_W-1:0] o_rs,
    output logic [mips_pkg::REG_ADDR_W-1:0] o_rt,
    output logic                            o_is_branch,
    output logic                            o_uses_rt,
    output logic [mips_pkg::DATA_W-1:0]     o_ex_a,
    output logic [mips_pkg::DATA_W-1:0]     o_ex_b,
    output logic [mips_pkg::DATA_W-1:0]     o_ex_imm,
    output logic [mips_pkg::REG_ADDR_W-1:0] o_ex_rs,
    output logic [mips_pkg::REG_ADDR_W-1:0] o_ex_rt,
    output logic [mips_pkg::REG_ADDR_W-1:0] o_ex_rd,
    output logic [2:0]                      o_ex_alu_op,
    output logic                            o_ex_alu_src,
    output logic                            o_ex_reg_write,
    output logic                            o_ex_mem_read,
    output logic                            o_ex_mem_write
);
    import mips_pkg::*;

    instr_t                ins;
    logic [DATA_W-1:0]     regs [2**REG_ADDR_W];
    logic [DATA_W-1:0]     rs_val, rt_val, br_a, br_b, imm;
    logic [REG_ADDR_W-1:0] dest;
    logic [2:0]            alu_op;
    logic                  alu_src, reg_write, mem_read, mem_write, is_jump, taken;

    // r0 reads zero; a write in the same cycle is passed through
    function automatic logic [DATA_W-1:0] read_reg(input logic [REG_ADDR_W-1:0] addr);
        if (addr == '0) begin
            return '0;
        end
        if (i_wb_we && i_wb_addr == addr) begin
            return i_wb_data;
        end
        return regs[addr];
    endfunction

    assign ins    = i_instr;
    assign o_rs   = ins.r.rs;
    assign o_rt   = ins.r.rt;
    assign imm    = {{16{ins.i.imm16[15]}}, ins.i.imm16};
    assign rs_val = read_reg(o_rs);
    assign rt_val = read_reg(o_rt);

    always_comb begin
        alu_op      = ALU_ADD;
        alu_src     = 1'b0;
        reg_write   = 1'b0;
        mem_read    = 1'b0;
        mem_write   = 1'b0;
        is_jump     = 1'b0;
        o_is_branch = 1'b0;
        o_uses_rt   = 1'b0;
        dest        = ins.i.rt; // I-type writes rt
        case (ins.r.opcode)
            OP_RTYPE: begin
                o_uses_rt = 1'b1;
                dest      = ins.r.rd;
                reg_write = 1'b1;
                case (ins.r.funct)
                    FN_ADDU: alu_op = ALU_ADD;
                    FN_SUBU: alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_SLT:  alu_op = ALU_SLT;
                    default: reg_write = 1'b0; // Unsupported funct retires nothing
                endcase
            end
            OP_ADDI: begin
                alu_src   = 1'b1;
                reg_write = 1'b1;
            end
            OP_LW: begin
                alu_src   = 1'b1;
                reg_write = 1'b1;
                mem_read  = 1'b1;
            end
            OP_SW: begin
                alu_src   = 1'b1;
                mem_write = 1'b1;
                o_uses_rt = 1'b1; // Store data
            end
            OP_BEQ, OP_BNE: begin
                o_is_branch = 1'b1;
                o_uses_rt   = 1'b1;
            end
            OP_J:    is_jump = 1'b1;
            default: ;
        endcase
    end

    // Branch operands, ALU results bypassed from EX/MEM
    assign br_a  = (i_exmem_reg_write && i_exmem_rd == o_rs) ? i_exmem_alu : rs_val;
    assign br_b  = (i_exmem_reg_write && i_exmem_rd == o_rt) ? i_exmem_alu : rt_val;
    assign taken = o_is_branch && ((br_a == br_b) == (ins.r.opcode == OP_BEQ));

    assign o_redirect = taken || is_jump;
    assign o_target   = is_jump ? {i_pc4[31:28], ins.j.target26, 2'b00}
                                : i_pc4 + {imm[DATA_W-3:0], 2'b00};

    always_ff @(posedge i_clk) begin
        if (i_wb_we) begin
            regs[i_wb_addr] <= i_wb_data;
        end
    end

    // ID/EX control, a bubble while held
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            o_ex_reg_write <= 1'b0;
            o_ex_mem_read  <= 1'b0;
            o_ex_mem_write <= 1'b0;
            o_ex_rd        <= '0;
        end else if (!i_stall) begin
            o_ex_reg_write <= reg_write && dest != '0 && !i_hold;
            o_ex_mem_read  <= mem_read && !i_hold;
            o_ex_mem_write <= mem_write && !i_hold;
            o_ex_rd        <= i_hold ? '0 : dest;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_stall) begin
            o_ex_a       <= rs_val;
            o_ex_b       <= rt_val;
            o_ex_imm     <= imm;
            o_ex_rs      <= o_rs;
            o_ex_rt      <= o_rt;
            o_ex_alu_op  <= alu_op;
            o_ex_alu_src <= alu_src;
        end
    end

    assert property (@(posedge i_clk) disable iff (i_rst) i_wb_we |-> i_wb_addr != '0)
        else $error("Writeback targets register 0");

endmodule

// ==== src/instruction_fetch.sv ====
module instruction_fetch #(
    parameter int IMEM_DEPTH = 64
) (
    input  logic                          i_clk,
    input  logic                          i_rst,
    input  logic                          i_stall,
    input  logic                          i_hold,
    input  logic                          i_flush,
    input  logic                          i_redirect,
    input  logic [mips_pkg::DATA_W-1:0]   i_target,
    input  logic                          i_imem_we,
    input  logic [$clog2(IMEM_DEPTH)-1:0] i_imem_addr,
    input  logic [mips_pkg::DATA_W-1:0]   i_imem_data,
    output logic [mips_pkg::DATA_W-1:0]   o_pc,
    output logic [mips_pkg::DATA_W-1:0]   o_ifid_instr,
    output logic [mips_pkg::DATA_W-1:0]   o_ifid_pc4
);
    import mips_pkg::*;

    localparam int AW = $clog2(IMEM_DEPTH);

    logic [DATA_W-1:0] imem [IMEM_DEPTH];
    logic [DATA_W-1:0] pc4;
    logic              advance;

    assign pc4     = o_pc + DATA_W'(4);
    assign advance = !i_stall && !i_hold;

    always_ff @(posedge i_clk) begin
        if (i_imem_we) begin
            imem[i_imem_addr] <= i_imem_data; // Program load port, also during reset
        end
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            o_pc         <= '0;
            o_ifid_instr <= '0;
            o_ifid_pc4   <= '0;
        end else if (advance) begin
            o_pc         <= i_redirect ? i_target : pc4;
            o_ifid_instr <= i_flush ? '0 : imem[o_pc[AW+1:2]]; // Zero word is a no-op
            o_ifid_pc4   <= pc4;
        end
    end

    // A program must keep the PC inside the loaded memory
    assert property (@(posedge i_clk) disable iff (i_rst) o_pc < DATA_W'(IMEM_DEPTH * 4))
        else $error("PC %h is outside instruction memory", o_pc);

endmodule

// ==== src/mips.sv ====
module mips #(
    parameter int IMEM_DEPTH = 64,
    parameter int DMEM_DEPTH = 64
) (
    input  logic                            i_clk,
    input  logic                            i_rst,
    input  logic                            i_stall,
    input  logic                            i_imem_we,
    input  logic [$clog2(IMEM_DEPTH)-1:0]   i_imem_addr,
    input  logic [mips_pkg::DATA_W-1:0]     i_imem_data,
    input  logic [$clog2(DMEM_DEPTH)-1:0]   i_dmem_dbg_addr,
    output logic [mips_pkg::DATA_W-1:0]     o_dmem_dbg_data,
    output logic [mips_pkg::DATA_W-1:0]     o_pc,
    output logic                            o_wb_valid,
    output logic [mips_pkg::REG_ADDR_W-1:0] o_wb_addr,
    output logic [mips_pkg::DATA_W-1:0]     o_wb_data
);
    import mips_pkg::*;

    logic [DATA_W-1:0]     ifid_instr, ifid_pc4, target;
    logic                  redirect, hold, flush;
    logic [REG_ADDR_W-1:0] id_rs, id_rt;
    logic                  id_is_branch, id_uses_rt;
    logic [DATA_W-1:0]     ex_a, ex_b, ex_imm;
    logic [REG_ADDR_W-1:0] ex_rs, ex_rt, ex_rd;
    logic [2:0]            ex_alu_op;
    logic                  ex_alu_src, ex_reg_write, ex_mem_read, ex_mem_write;
    logic [DATA_W-1:0]     mem_alu, mem_store;
    logic [REG_ADDR_W-1:0] mem_rd;
    logic                  mem_reg_write, mem_mem_read, mem_mem_write;
    logic [DATA_W-1:0]     wb_alu, wb_load, wb_data;
    logic [REG_ADDR_W-1:0] wb_rd;
    logic                  wb_reg_write, wb_mem_to_reg, wb_we;

    instruction_fetch #(.IMEM_DEPTH(IMEM_DEPTH)) u_fetch (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_stall      (i_stall),
        .i_hold       (hold),
        .i_flush      (flush),
        .i_redirect   (redirect),
        .i_target     (target),
        .i_imem_we    (i_imem_we),
        .i_imem_addr  (i_imem_addr),
        .i_imem_data  (i_imem_data),
        .o_pc         (o_pc),
        .o_ifid_instr (ifid_instr),
        .o_ifid_pc4   (ifid_pc4)
    );

    hazard_detection u_hazard (
        .i_id_rs        (id_rs),
        .i_id_rt        (id_rt),
        .i_id_is_branch (id_is_branch),
        .i_id_uses_rt   (id_uses_rt),
        .i_ex_rd        (ex_rd),
        .i_ex_reg_write (ex_reg_write),
        .i_ex_mem_read  (ex_mem_read),
        .i_mem_rd       (mem_rd),
        .i_mem_mem_read (mem_mem_read),
        .i_redirect     (redirect),
        .o_hold         (hold),
        .o_flush        (flush)
    );

    instruction_decode u_decode (
        .i_clk             (i_clk),
        .i_rst             (i_rst),
        .i_stall           (i_stall),
        .i_hold            (hold),
        .i_instr           (ifid_instr),
        .i_pc4             (ifid_pc4),
        .i_wb_we           (wb_we),
        .i_wb_addr         (wb_rd),
        .i_wb_data         (wb_data),
        .i_exmem_rd        (mem_rd),
        .i_exmem_reg_write (mem_reg_write),
        .i_exmem_alu       (mem_alu),
        .o_redirect        (redirect),
        .o_target          (target),
        .o_rs              (id_rs),
        .o_rt              (id_rt),
        .o_is_branch       (id_is_branch),
        .o_uses_rt         (id_uses_rt),
        .o_ex_a            (ex_a),
        .o_ex_b            (ex_b),
        .o_ex_imm          (ex_imm),
        .o_ex_rs           (ex_rs),
        .o_ex_rt           (ex_rt),
        .o_ex_rd           (ex_rd),
        .o_ex_alu_op       (ex_alu_op),
        .o_ex_alu_src      (ex_alu_src),
        .o_ex_reg_write    (ex_reg_write),
        .o_ex_mem_read     (ex_mem_read),
        .o_ex_mem_write    (ex_mem_write)
    );

    execution u_execute (
        .i_clk           (i_clk),
        .i_rst           (i_rst),
        .i_stall         (i_stall),
        .i_a             (ex_a),
        .i_b             (ex_b),
        .i_imm           (ex_imm),
        .i_rs            (ex_rs),
        .i_rt            (ex_rt),
        .i_rd            (ex_rd),
        .i_alu_op        (ex_alu_op),
        .i_alu_src       (ex_alu_src),
        .i_reg_write     (ex_reg_write),
        .i_mem_read      (ex_mem_read),
        .i_mem_write     (ex_mem_write),
        .i_wb_we         (wb_we),
        .i_wb_addr       (wb_rd),
        .i_wb_data       (wb_data),
        .o_mem_alu       (mem_alu),
        .o_mem_store     (mem_store),
        .o_mem_rd        (mem_rd),
        .o_mem_reg_write (mem_reg_write),
        .o_mem_mem_read  (mem_mem_read),
        .o_mem_mem_write (mem_mem_write)
    );

    data_memory #(.DMEM_DEPTH(DMEM_DEPTH)) u_memory (
        .i_clk           (i_clk),
        .i_rst           (i_rst),
        .i_stall         (i_stall),
        .i_alu           (mem_alu),
        .i_store         (mem_store),
        .i_rd            (mem_rd),
        .i_reg_write     (mem_reg_write),
        .i_mem_read      (mem_mem_read),
        .i_mem_write     (mem_mem_write),
        .i_dbg_addr      (i_dmem_dbg_addr),
        .o_dbg_data      (o_dmem_dbg_data),
        .o_wb_alu        (wb_alu),
        .o_wb_load       (wb_load),
        .o_wb_rd         (wb_rd),
        .o_wb_reg_write  (wb_reg_write),
        .o_wb_mem_to_reg (wb_mem_to_reg)
    );

    // Writeback mux, register write held off while stalled
    assign wb_data = wb_mem_to_reg ? wb_load : wb_alu;
    assign wb_we   = wb_reg_write && !i_stall;

    assign o_wb_valid = wb_we;
    assign o_wb_addr  = wb_rd;
    assign o_wb_data  = wb_data;

endmodule

// ==== src/mips_pkg.sv ====
package mips_pkg;

    localparam int DATA_W     = 32;
    localparam int REG_ADDR_W = 5;

    // Primary opcodes
    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_J     = 6'h02;
    localparam logic [5:0] OP_BEQ   = 6'h04;
    localparam logic [5:0] OP_BNE   = 6'h05;
    localparam logic [5:0] OP_ADDI  = 6'h08;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SW    = 6'h2b;

    // R-type funct field
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_SLT  = 6'h2a;

    localparam logic [2:0] ALU_ADD = 3'd0;
    localparam logic [2:0] ALU_SUB = 3'd1;
    localparam logic [2:0] ALU_AND = 3'd2;
    localparam logic [2:0] ALU_OR  = 3'd3;
    localparam logic [2:0] ALU_SLT = 3'd4; // Signed set-less-than

    // One instruction word, three field layouts
    typedef union packed {
        struct packed {
            logic [5:0] opcode;
            logic [4:0] rs;
            logic [4:0] rt;
            logic [4:0] rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } r;
        struct packed {
            logic [5:0]  opcode;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [15:0] imm16;
        } i;
        struct packed {
            logic [5:0]  opcode;
            logic [25:0] target26;
        } j;
    } instr_t;

endpackage
